/* project.f */
rtl/useq_pkg.sv
rtl/useq_timing.sv
rtl/useq_control.sv
rtl/spc_stack.sv
rtl/upc_select.sv
rtl/ustore.sv
rtl/useq_top.sv
test/useq_properties.sv
test/useq_tb.sv

/* rtl/spc_stack.sv */
//********************************************************************
// subroutine return stack. ptr points at the top entry.
// no overflow guard: a push past the last entry wraps the pointer.
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module spc_stack
  (
   input  logic                           clk,
   input  logic                           reset,
   input  useq_pkg::ucycle_t              cycle,
   input  useq_pkg::seq_ctl_t             ctl,
   input  logic [useq_pkg::ADDR_W-1:0]    ipc,
   output logic [useq_pkg::ADDR_W-1:0]    spc,
   output logic [useq_pkg::SPC_PTR_W-1:0] ptr
   );

   import useq_pkg::*;

   logic [ADDR_W-1:0]    stack_mem [SPC_DEPTH];
   logic [SPC_PTR_W-1:0] push_ptr;
   logic                 do_push;
   logic                 do_pop;

   assign push_ptr = ptr + 1'b1;
   assign do_push  = ctl.spush & (cycle == CYC_WRITE);
   assign do_pop   = ctl.spop & (cycle == CYC_WRITE);

   // pointer moves on the write phase.
   always_ff @(posedge clk)
   begin
      if (reset)
         ptr <= '0;
      else if (do_push)
         ptr <= push_ptr;
      else if (do_pop)
         ptr <= ptr - 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (do_push)
         stack_mem[push_ptr] <= ipc;   // return address.
   end

   // top read is combinational, so a pop returns the old top.
   assign spc = stack_mem[ptr];

endmodule

`default_nettype wire

/* rtl/upc_select.sv */
//********************************************************************
// next address mux and micro-pc. upc loads on the edge into fetch.
// first load after reset is forced to address 0.
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module upc_select
  (
   input  logic                          clk,
   input  logic                          reset,
   input  useq_pkg::ucycle_t             cycle,
   input  useq_pkg::seq_ctl_t            ctl,
   input  useq_pkg::uinst_fields_t       fields,
   input  logic [2:0]                    cond_sel,
   input  logic [useq_pkg::COND_W-1:0]   cond,
   input  logic [useq_pkg::ADDR_W-1:0]   spc,
   input  logic [useq_pkg::ADDR_W-1:0]   dpc,
   output logic                          jcond,
   output logic [useq_pkg::ADDR_W-1:0]   upc,
   output logic [useq_pkg::ADDR_W-1:0]   ipc
   );

   import useq_pkg::*;

   logic [ADDR_W-1:0] npc;
   logic              boot;   // set until the first load.

   assign jcond = cond[cond_sel];   // raw sense.
   assign ipc   = upc + 1'b1;

   always_comb
   begin
      unique case (ctl.pcs)
         PCS_SPC: npc = spc;
         PCS_IR:  npc = fields.jump_addr;
         PCS_DPC: npc = dpc;
         default: npc = ipc;
      endcase
   end

   //*****************************************************************
   // upc register. loads together with the stack update.
   //*****************************************************************
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         upc  <= '0;
         boot <= 1'b1;
      end
      else if (cycle == CYC_WRITE)
      begin
         upc  <= boot ? '0 : npc;
         boot <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* rtl/useq_control.sv */
//********************************************************************
// pc/spc control. all combinational apart from inop and iwrited.
// a no-op instruction ignores its own fields; a pending write still returns.
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module useq_control
  (
   input  logic                    clk,
   input  logic                    reset,
   input  useq_pkg::ucycle_t       cycle,
   input  useq_pkg::uinst_fields_t fields,
   input  useq_pkg::disp_entry_t   disp,
   input  logic                    jcond,
   input  logic                    trap,
   output useq_pkg::seq_ctl_t      ctl
   );

   import useq_pkg::*;

   logic       inop;
   logic       iwrited;
   logic       nop;
   logic       jmp;
   logic       taken;
   logic       jret;
   logic       iwrite;
   logic       dispenb;
   logic       dfall;
   logic       ignpopj;
   logic       popj;
   logic       srcpop;
   logic       spush;
   logic       spop;
   logic       n;
   logic [1:0] pcs;

   assign nop = trap | inop;

   //*****************************************************************
   // instruction decode, gated by nop.
   //*****************************************************************
   assign jmp     = fields.irjump & ~nop;
   assign taken   = jmp & (jcond ^ fields.invert);        // sense applied.
   assign jret    = jmp & ~fields.call & fields.ret;
   assign iwrite  = taken & fields.call & fields.ret;     // microcode write.
   assign dispenb = fields.irdisp & ~fields.funct[2] & ~nop;
   assign dfall   = disp.dr & disp.dp;                    // push-pop falls through.
   assign ignpopj = fields.irdisp & ~nop & ~disp.dr;
   assign srcpop  = fields.srcspcpop & ~nop;

   // a pending write returns through the stack.
   assign popj = (fields.popj & ~nop) | iwrited;

   assign spop = ((srcpop | popj) & ~ignpopj) |
                 (dispenb & disp.dr & ~disp.dp) |
                 (taken & jret);

   assign spush = (fields.destspc & ~nop) |
                  (taken & fields.call) |
                  (dispenb & disp.dp & ~disp.dr);

   // next pc select.
   always_comb
   begin
      if (popj & ~ignpopj)
         pcs = PCS_SPC;
      else if (taken & jret)
         pcs = PCS_SPC;
      else if (taken)
         pcs = PCS_IR;
      else if (dispenb & disp.dr & ~disp.dp)
         pcs = PCS_SPC;
      else if (dispenb & ~dfall)
         pcs = PCS_DPC;
      else
         pcs = PCS_IPC;
   end

   // inhibit the following instruction.
   assign n = trap |
              iwrite |
              (dispenb & disp.dn) |
              (taken & fields.next_inhibit);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         inop    <= 1'b0;
         iwrited <= 1'b0;
      end
      else if (cycle == CYC_FETCH)
      begin
         inop    <= n;
         iwrited <= iwrite;
      end
   end

   always_comb
   begin
      ctl.pcs      = pcs;
      ctl.spush    = spush;
      ctl.spop     = spop;
      ctl.nop      = nop;
      ctl.nopa     = inop;
      ctl.iwrited  = iwrited;
      ctl.spcdrive = (fields.srcspc | fields.srcspcpop) & (cycle != CYC_DECODE);
   end

endmodule

`default_nettype wire

/* rtl/useq_pkg.sv */
//********************************************************************
// widths, microword field positions and shared types.
// field layout follows a 49-bit cadr-style microinstruction.
//********************************************************************
`default_nettype none

package useq_pkg;

   localparam int ADDR_W      = 8;
   localparam int STORE_DEPTH = 256;
   localparam int SPC_DEPTH   = 32;
   localparam int SPC_PTR_W   = 5;
   localparam int IR_W        = 49;
   localparam int DISP_DEPTH  = 64;
   localparam int DISP_AW     = 6;
   localparam int COND_W      = 8;

   //*****************************************************************
   // microinstruction field positions.
   //*****************************************************************
   localparam int JADDR_HI  = 19;
   localparam int JADDR_LO  = 12;
   localparam int CSEL_HI   = 2;       // condition select.
   localparam int CSEL_LO   = 0;
   localparam int INV_BIT   = 6;
   localparam int N_BIT     = 7;       // next inhibit.
   localparam int CALL_BIT  = 8;
   localparam int RET_BIT   = 9;
   localparam int POPJ_BIT  = 42;
   localparam int OP_HI     = 44;
   localparam int OP_LO     = 43;
   localparam int FUNCT_HI  = 41;
   localparam int FUNCT_LO  = 38;
   localparam int DBASE_HI  = 29;
   localparam int DBASE_LO  = 24;
   localparam int DWIDTH_HI = 23;
   localparam int DWIDTH_LO = 21;
   localparam int MSRC_HI   = 31;      // alu ops only.
   localparam int MSRC_LO   = 26;
   localparam int DEST_HI   = 23;      // alu ops only.
   localparam int DEST_LO   = 19;

   localparam logic [1:0] OP_ALU  = 2'b00;
   localparam logic [1:0] OP_JUMP = 2'b01;
   localparam logic [1:0] OP_DISP = 2'b10;
   localparam logic [1:0] OP_BYTE = 2'b11;

   localparam logic [5:0] MSRC_SPC    = 6'h21;  // read stack top.
   localparam logic [5:0] MSRC_SPCPOP = 6'h25;  // read top and pop.
   localparam logic [4:0] DEST_SPC    = 5'h0a;  // push.

   // next-pc select codes.
   localparam logic [1:0] PCS_SPC = 2'd0;
   localparam logic [1:0] PCS_IR  = 2'd1;
   localparam logic [1:0] PCS_DPC = 2'd2;
   localparam logic [1:0] PCS_IPC = 2'd3;

   typedef enum logic [1:0] {
      CYC_DECODE = 2'd0,
      CYC_ALU    = 2'd1,
      CYC_WRITE  = 2'd2,
      CYC_FETCH  = 2'd3
   } ucycle_t;

   typedef struct packed {
      logic              dn;
      logic              dp;
      logic              dr;
      logic [ADDR_W-1:0] target;
   } disp_entry_t;

   typedef struct packed {
      logic              irjump;
      logic              irdisp;
      logic [3:0]        funct;
      logic              invert;
      logic              next_inhibit;
      logic              call;
      logic              ret;
      logic              popj;
      logic              srcspc;
      logic              srcspcpop;
      logic              destspc;
      logic [ADDR_W-1:0] jump_addr;
   } uinst_fields_t;

   typedef struct packed {
      logic [1:0] pcs;
      logic       spush;
      logic       spop;
      logic       nop;
      logic       nopa;
      logic       iwrited;
      logic       spcdrive;
   } seq_ctl_t;

endpackage

`default_nettype wire

/* rtl/useq_timing.sv */
//********************************************************************
// four-phase machine cycle, one microinstruction per four clocks.
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module useq_timing
  (
   input  logic              clk,
   input  logic              reset,
   output useq_pkg::ucycle_t cycle
   );

   import useq_pkg::*;

   ucycle_t cycle_nxt;

   always_comb
   begin
      unique case (cycle)
         CYC_DECODE: cycle_nxt = CYC_ALU;
         CYC_ALU:    cycle_nxt = CYC_WRITE;
         CYC_WRITE:  cycle_nxt = CYC_FETCH;
         default:    cycle_nxt = CYC_DECODE;   // fetch wraps.
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         cycle <= CYC_DECODE;
      else
         cycle <= cycle_nxt;
   end

endmodule

`default_nettype wire

/* rtl/useq_top.sv */
//********************************************************************
// microprogram sequencer top. no data path; cond, dispatch byte and
// write data come from ports. load the store while reset is held.
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module useq_top
  (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           load_en,
   input  logic                           load_disp,
   input  logic [7:0]                     load_addr,
   input  logic [useq_pkg::IR_W-1:0]      load_data,
   input  logic [useq_pkg::IR_W-1:0]      wdata,
   input  logic [useq_pkg::COND_W-1:0]    cond,
   input  logic [7:0]                     disp_byte,
   input  logic                           trap,
   output logic [useq_pkg::ADDR_W-1:0]    upc,
   output logic [useq_pkg::IR_W-1:0]      ir,
   output logic                           nop,
   output logic [useq_pkg::ADDR_W-1:0]    spc,
   output logic [useq_pkg::SPC_PTR_W-1:0] spc_ptr
   );

   import useq_pkg::*;

   ucycle_t           cycle;
   uinst_fields_t     fields;
   disp_entry_t       disp;
   seq_ctl_t          ctl;
   logic [2:0]        cond_sel;
   logic              jcond;
   logic [ADDR_W-1:0] ipc;

   assign nop = ctl.nop;

   useq_timing useq_timing_inst
     (.clk(clk), .reset(reset), .cycle(cycle));

   ustore ustore_inst
     (.clk(clk), .reset(reset), .cycle(cycle),
      .load_en(load_en), .load_disp(load_disp), .load_addr(load_addr),
      .load_data(load_data), .iwrited(ctl.iwrited), .wdata(wdata),
      .upc(upc), .disp_byte(disp_byte), .ir(ir), .fields(fields),
      .cond_sel(cond_sel), .disp(disp));

   useq_control useq_control_inst
     (.clk(clk), .reset(reset), .cycle(cycle), .fields(fields),
      .disp(disp), .jcond(jcond), .trap(trap), .ctl(ctl));

   spc_stack spc_stack_inst
     (.clk(clk), .reset(reset), .cycle(cycle), .ctl(ctl),
      .ipc(ipc), .spc(spc), .ptr(spc_ptr));

   // dispatch target feeds the dpc input.
   upc_select upc_select_inst
     (.clk(clk), .reset(reset), .cycle(cycle), .ctl(ctl),
      .fields(fields), .cond_sel(cond_sel), .cond(cond),
      .spc(spc), .dpc(disp.target), .jcond(jcond),
      .upc(upc), .ipc(ipc));

endmodule

`default_nettype wire

/* rtl/ustore.sv */
//********************************************************************
// control store, dispatch table and ir. host loads only under reset.
// microcode writes land at upc, which holds the write jump target.
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module ustore
  (
   input  logic                           clk,
   input  logic                           reset,
   input  useq_pkg::ucycle_t              cycle,
   input  logic                           load_en,
   input  logic                           load_disp,
   input  logic [7:0]                     load_addr,
   input  logic [useq_pkg::IR_W-1:0]      load_data,
   input  logic                           iwrited,
   input  logic [useq_pkg::IR_W-1:0]      wdata,
   input  logic [useq_pkg::ADDR_W-1:0]    upc,
   input  logic [7:0]                     disp_byte,
   output logic [useq_pkg::IR_W-1:0]      ir,
   output useq_pkg::uinst_fields_t        fields,
   output logic [2:0]                     cond_sel,
   output useq_pkg::disp_entry_t          disp
   );

   import useq_pkg::*;

   logic [IR_W-1:0]    store_mem [STORE_DEPTH];
   disp_entry_t        disp_mem  [DISP_DEPTH];
   logic [1:0]         op;
   logic [2:0]         dwidth;
   logic [7:0]         dmask;
   logic [DISP_AW-1:0] didx;

   //*****************************************************************
   // writes. host port first, then microcode write on the write phase.
   //*****************************************************************
   always_ff @(posedge clk)
   begin
      if (load_en & ~load_disp)
         store_mem[load_addr] <= load_data;
      else if (iwrited && cycle == CYC_WRITE)
         store_mem[upc] <= wdata;
   end

   always_ff @(posedge clk)
   begin
      if (load_en & load_disp)
         disp_mem[load_addr[DISP_AW-1:0]] <= disp_entry_t'(load_data[$bits(disp_entry_t)-1:0]);
   end

   // ir clears to an alu no-op.
   always_ff @(posedge clk)
   begin
      if (reset)
         ir <= '0;
      else if (cycle == CYC_FETCH)
         ir <= store_mem[upc];
   end

   //*****************************************************************
   // field decode.
   //*****************************************************************
   assign op       = ir[OP_HI:OP_LO];
   assign cond_sel = ir[CSEL_HI:CSEL_LO];

   always_comb
   begin
      fields.irjump       = (op == OP_JUMP);
      fields.irdisp       = (op == OP_DISP);
      fields.funct        = ir[FUNCT_HI:FUNCT_LO];
      fields.invert       = ir[INV_BIT];
      fields.next_inhibit = ir[N_BIT];
      fields.call         = ir[CALL_BIT];
      fields.ret          = ir[RET_BIT];
      fields.popj         = ir[POPJ_BIT];
      fields.srcspc       = (op == OP_ALU) && (ir[MSRC_HI:MSRC_LO] == MSRC_SPC);
      fields.srcspcpop    = (op == OP_ALU) && (ir[MSRC_HI:MSRC_LO] == MSRC_SPCPOP);
      fields.destspc      = (op == OP_ALU) && (ir[DEST_HI:DEST_LO] == DEST_SPC);
      fields.jump_addr    = ir[JADDR_HI:JADDR_LO];
   end

   // dispatch index is base plus the masked byte, modulo table size.
   assign dwidth = ir[DWIDTH_HI:DWIDTH_LO];
   assign dmask  = (8'd1 << dwidth) - 8'd1;
   assign didx   = ir[DBASE_HI:DBASE_LO] + DISP_AW'(disp_byte & dmask);
   assign disp   = disp_mem[didx];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the sequencer testbench with verilator.
# the exit status is the simulator's; a failing run ends in $fatal.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f project.f \
   --top-module useq_tb \
   -o useq_sim \
   && ./obj_dir/useq_sim \
   || exit 1

/* test/useq_properties.sv */
//********************************************************************
// stack and cycle rules, bound to useq_top.
// ptr wrap in either direction is treated as an error.
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module useq_properties
  (
   input  logic                           clk,
   input  logic                           reset,
   input  useq_pkg::ucycle_t              cycle,
   input  useq_pkg::seq_ctl_t             ctl,
   input  logic [useq_pkg::ADDR_W-1:0]    upc,
   input  logic [useq_pkg::SPC_PTR_W-1:0] ptr
   );

   import useq_pkg::*;

   // push on a full stack or pop on an empty one.
   no_wrap: assert property (@(posedge clk) disable iff (reset)
      (cycle == CYC_WRITE) |->
         !((ctl.spush && ptr == SPC_PTR_W'(SPC_DEPTH - 1)) ||
           (!ctl.spush && ctl.spop && ptr == '0)))
      else $error("stack pointer wrapped");

   upc_on_fetch: assert property (@(posedge clk) disable iff (reset)
      (cycle != CYC_WRITE) |=> $stable(upc))   // loads only into fetch.
      else $error("upc changed outside the fetch edge");

   no_push_pop: assert property (@(posedge clk) disable iff (reset)
      (cycle == CYC_WRITE) |-> !(ctl.spush && ctl.spop))
      else $error("push and pop in one instruction");

endmodule

`default_nettype wire

/* test/useq_tb.sv */
//********************************************************************
// sequencer testbench with an instruction-level reference model.
// reset is held through the host load, then 16 more cycles.
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module useq_tb;

   localparam int RESET_CYCLES = 16;
   localparam int LOAD_CYCLES  = 256 + 64 + 1;
   localparam int NUM_INSTR    = 400;
   localparam int TIMEOUT      = LOAD_CYCLES + RESET_CYCLES + 4 * (NUM_INSTR + 2) + 16;

   logic        clk;
   logic        reset;
   logic        load_en;
   logic        load_disp;
   logic [7:0]  load_addr;
   logic [48:0] load_data;
   logic [48:0] wdata;
   logic [7:0]  cond;
   logic [7:0]  disp_byte;
   logic        trap;
   logic [7:0]  upc;
   logic [48:0] ir;
   logic        nop;
   logic [7:0]  spc;
   logic [4:0]  spc_ptr;

   // reference model state.
   logic [48:0] store_m [256];
   logic [10:0] disp_m  [64];     // {dn, dp, dr, target}.
   logic [7:0]  stack_m [32];
   logic [7:0]  m_upc;
   logic [4:0]  m_ptr;
   logic        m_inop;
   logic        m_iwrited;
   logic [7:0]  cond_v;
   logic [7:0]  byte_v;
   logic        trap_v;
   logic [48:0] wdata_v;
   int          cycle_count;
   int unsigned seed_val;

   useq_top useq_top_inst
     (.clk(clk), .reset(reset), .load_en(load_en), .load_disp(load_disp),
      .load_addr(load_addr), .load_data(load_data), .wdata(wdata),
      .cond(cond), .disp_byte(disp_byte), .trap(trap), .upc(upc),
      .ir(ir), .nop(nop), .spc(spc), .spc_ptr(spc_ptr));

   bind useq_top useq_properties useq_properties_inst
     (.clk(clk), .reset(reset), .cycle(cycle), .ctl(ctl),
      .upc(upc), .ptr(spc_ptr));

   always #50 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT)
      begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
         $display("Something failed");
         $fatal(1, "timeout");
      end
   end

   //*****************************************************************
   // microword builders.
   //*****************************************************************
   function automatic logic [48:0] jump_word(input logic [7:0] target, input logic [2:0] csel,
                                             input logic inv, input logic call,
                                             input logic ret, input logic nbit);
      logic [48:0] w;
      w          = '0;
      w[44:43]   = 2'b01;
      w[19:12]   = target;
      w[2:0]     = csel;
      w[6]       = inv;
      w[7]       = nbit;
      w[8]       = call;
      w[9]       = ret;
      return w;
   endfunction

   function automatic logic [48:0] disp_word(input logic [5:0] base, input logic [2:0] width);
      logic [48:0] w;
      w        = '0;
      w[44:43] = 2'b10;
      w[29:24] = base;
      w[23:21] = width;
      return w;
   endfunction

   function automatic logic [48:0] alu_word(input logic popj, input logic [5:0] marker);
      logic [48:0] w;
      w        = '0;
      w[42]    = popj;
      w[37:32] = marker;   // clear of the msrc and dest fields.
      return w;
   endfunction

   task automatic build_program();
      logic [48:0] w;
      for (int a = 0; a < 256; a++)
      begin
         w        = jump_word(8'd0, 3'd0, a[0], 1'b0, 1'b0, 1'b0);  // back to 0.
         w[37:30] = a[7:0];
         store_m[a] = w;
      end
      for (int d = 0; d < 64; d++)
         disp_m[d] = {3'b000, 2'b11, d[5:0]};
      for (int a = 0; a < 4; a++)
         store_m[a] = alu_word(1'b0, a[5:0]);
      store_m[4]  = jump_word(8'd10, 3'd0, 1'b0, 1'b0, 1'b0, 1'b0);
      store_m[5]  = jump_word(8'd12, 3'd3, 1'b1, 1'b0, 1'b0, 1'b0);
      store_m[6]  = jump_word(8'd40, 3'd1, 1'b0, 1'b1, 1'b0, 1'b0);  // call.
      store_m[7]  = disp_word(6'd0, 3'd2);
      store_m[8]  = alu_word(1'b0, 6'd8);
      store_m[9]  = jump_word(8'd60, 3'd2, 1'b0, 1'b1, 1'b1, 1'b0);  // microcode write.
      store_m[10] = jump_word(8'd14, 3'd4, 1'b0, 1'b0, 1'b0, 1'b1);  // inhibits next.
      for (int a = 11; a < 14; a++)
         store_m[a] = alu_word(1'b0, a[5:0]);
      store_m[14] = jump_word(8'd60, 3'd5, 1'b0, 1'b0, 1'b0, 1'b0);
      store_m[20] = alu_word(1'b0, 6'd20);
      store_m[22] = alu_word(1'b0, 6'd22);
      store_m[40] = alu_word(1'b0, 6'd40);
      store_m[41] = jump_word(8'd50, 3'd6, 1'b0, 1'b1, 1'b0, 1'b0);  // nested call.
      store_m[42] = jump_word(8'd0, 3'd7, 1'b0, 1'b0, 1'b1, 1'b0);   // conditional return.
      store_m[43] = alu_word(1'b1, 6'd43);
      store_m[50] = disp_word(6'd4, 3'd1);
      store_m[51] = alu_word(1'b1, 6'd51);
      store_m[52] = alu_word(1'b0, 6'd52);
      store_m[53] = alu_word(1'b1, 6'd53);
      store_m[60] = alu_word(1'b0, 6'h3f);
      disp_m[0] = {3'b000, 8'd20};
      disp_m[1] = {3'b010, 8'd40};   // dp pushes.
      disp_m[2] = {3'b011, 8'd99};   // dp and dr fall through.
      disp_m[3] = {3'b100, 8'd22};
      disp_m[4] = {3'b001, 8'd0};    // dr returns.
      disp_m[5] = {3'b100, 8'd52};
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
         $display("Something failed");
         $fatal(1, "value check");
      end
   endtask

   //*****************************************************************
   // reference model, one instruction per call.
   //*****************************************************************
   task automatic model_step();
      logic [48:0] w;
      logic        nop_m;
      logic        taken;
      logic        wr;
      logic        dsp;
      logic        ign;
      logic        popj;
      logic        push;
      logic        pop;
      logic [5:0]  idx;
      logic [10:0] ent;
      logic [7:0]  nxt;
      logic [7:0]  top;
      w     = store_m[m_upc];
      nop_m = trap_v | m_inop;
      top   = stack_m[m_ptr];
      taken = (w[44:43] == 2'b01) && !nop_m && (cond_v[w[2:0]] ^ w[6]);
      wr    = taken && w[8] && w[9];
      dsp   = (w[44:43] == 2'b10) && !w[40] && !nop_m;
      idx   = w[29:24] + 6'(byte_v & ((8'd1 << w[23:21]) - 8'd1));
      ent   = disp_m[idx];
      ign   = (w[44:43] == 2'b10) && !nop_m && !ent[8];
      popj  = (w[42] && !nop_m) || m_iwrited;
      push  = 1'b0;
      pop   = 1'b0;
      nxt   = m_upc + 8'd1;
      if (popj && !ign)
      begin
         nxt = top;
         pop = 1'b1;
      end
      else if (taken && w[9] && !w[8])
      begin
         nxt = top;
         pop = 1'b1;
      end
      else if (taken)
      begin
         nxt  = w[19:12];
         push = w[8];
      end
      else if (dsp && ent[8] && !ent[9])
      begin
         nxt = top;
         pop = 1'b1;
      end
      else if (dsp && !(ent[8] && ent[9]))
      begin
         nxt  = ent[7:0];
         push = ent[9];
      end
      if (m_iwrited)
         store_m[m_upc] = wdata_v;    // lands at the write target.
      if (push)
      begin
         m_ptr          = m_ptr + 5'd1;
         stack_m[m_ptr] = m_upc + 8'd1;
      end
      else if (pop)
         m_ptr = m_ptr - 5'd1;
      m_inop    = trap_v || wr || (dsp && ent[10]) || (taken && w[7]);
      m_iwrited = wr;
      m_upc     = nxt;
   endtask

   initial
   begin
      clk         = 1'b0;
      reset       = 1'b1;
      load_en     = 1'b0;
      load_disp   = 1'b0;
      load_addr   = '0;
      load_data   = '0;
      cond        = '0;
      disp_byte   = '0;
      trap        = 1'b0;
      cycle_count = 0;
      seed_val    = $urandom(27);
      wdata_v     = alu_word(1'b0, 6'($urandom % 63));   // differs from the old word at 60.
      wdata       = wdata_v;
      build_program();

      // host load under reset.
      for (int a = 0; a < 256; a++)
      begin
         @(posedge clk);
         load_en   <= 1'b1;
         load_addr <= a[7:0];
         load_data <= store_m[a];
      end
      for (int d = 0; d < 64; d++)
      begin
         @(posedge clk);
         load_disp <= 1'b1;
         load_addr <= d[7:0];
         load_data <= {38'd0, disp_m[d]};
      end
      @(posedge clk);
      load_en   <= 1'b0;
      load_disp <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;

      // boot instruction, then ir holds address 0.
      repeat (4) @(posedge clk);
      m_upc     = '0;
      m_ptr     = '0;
      m_inop    = 1'b0;
      m_iwrited = 1'b0;
      for (int i = 0; i < NUM_INSTR; i++)
      begin
         cond_v    = 8'($urandom);
         byte_v    = 8'($urandom);
         // traps land on an alu op and on the call before a dispatch.
         trap_v    = ((m_upc == 8'd1) || (m_upc == 8'd6)) && ($urandom % 3 == 0);
         cond      <= cond_v;
         disp_byte <= byte_v;
         trap      <= trap_v;
         @(negedge clk);
         check_value("upc", 64'(upc), 64'(m_upc));
         check_value("ir", 64'(ir), 64'(store_m[m_upc]));
         check_value("spc_ptr", 64'(spc_ptr), 64'(m_ptr));
         check_value("nop", 64'(nop), 64'(trap_v | m_inop));
         if (m_ptr != 5'd0)
            check_value("spc", 64'(spc), 64'(stack_m[m_ptr]));
         model_step();
         repeat (4) @(posedge clk);
      end
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire
